// File: hw/memPkg.sv
package memPkg;

    // byte-wide RAM, 64 KiB address space
    localparam int memAddrBits = 16;
    localparam int memByteBits = 8;

    typedef logic [memByteBits-1:0] memByte;

    typedef logic [memAddrBits-1:0] memAddr;

    // one RAM cycle as issued by the controller
    typedef struct packed {
        logic   we;
        memAddr addr;
        memByte wdata;
    } ramCmd;

    // idle command, used as the default drive value
    localparam ramCmd ramIdleCmd = '{we: 1'b0, addr: '0, wdata: '0};

endpackage

// File: hw/cpuPkg.sv
package cpuPkg;

    localparam int addrBits = 16;
    localparam int dataBits = 32;

    // queue depths, also the starting credit count of each client
    localparam int fetchDepth = 2;
    localparam int dataDepth  = 4;

    typedef enum logic {
        opLoad,
        opStore
    } memOp;

    // byte count is 1, 2 or 4
    typedef enum logic [1:0] {
        sizeByte,
        sizeHalf,
        sizeWord
    } accSize;

    typedef struct packed {
        memOp                op;
        accSize              size;
        logic [addrBits-1:0] addr;
        logic [dataBits-1:0] wdata;
    } memReq;

    // valid is a single-cycle pulse; no back-pressure on responses
    typedef struct packed {
        logic                valid;
        logic [dataBits-1:0] rdata;
    } memResp;

endpackage

// File: hw/reqQueue.sv
`timescale 1ns/100ps

module reqQueue #(
    parameter int depth = 2
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          push,
    input  cpuPkg::memReq inReq,
    input  logic          pop,
    output cpuPkg::memReq head,
    output logic          notEmpty,
    output logic          creditRet
);

    localparam int ptrBits = (depth > 1) ? $clog2(depth) : 1;
    localparam int cntBits = $clog2(depth + 1);

    cpuPkg::memReq entries [depth];

    logic [ptrBits-1:0] wrPtr;
    logic [ptrBits-1:0] rdPtr;
    logic [cntBits-1:0] count;
    logic               full;

    assign full     = (count == cntBits'(depth));
    assign notEmpty = (count != '0);
    assign head     = entries[rdPtr];

    // payload storage, no reset
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wrPtr] <= inReq;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            count     <= '0;
            creditRet <= 1'b0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == ptrBits'(depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == ptrBits'(depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // one credit back per entry handed to the controller
            creditRet <= pop;
        end
    end

    // client pushed without holding a credit
    pushFullCheck: assert property (
        @(posedge clk) disable iff (rst)
        !(push && full)
    );

    // controller took a head that was not there
    popEmptyCheck: assert property (
        @(posedge clk) disable iff (rst)
        pop |-> notEmpty
    );

endmodule

// File: hw/memCtrl.sv
`timescale 1ns/100ps

module memCtrl (
    input  logic           clk,
    input  logic           rst,
    input  logic           ioFull,
    input  cpuPkg::memReq  fetchHead,
    input  cpuPkg::memReq  dataHead,
    input  logic           fetchValid,
    input  logic           dataValid,
    output logic           fetchPop,
    output logic           dataPop,
    output memPkg::ramCmd  cmd,
    input  memPkg::memByte rdByte,
    output cpuPkg::memResp fetchResp,
    output cpuPkg::memResp dataResp
);

    typedef enum logic [1:0] {
        idle,
        fetchBusy,
        loadBusy,
        storeBusy
    } ctrlState;

    ctrlState state;

    // stage 0..n-1 drive byte addresses, stage n returns the response
    logic [2:0] stage;
    logic [2:0] lastStage;

    memPkg::memAddr              curAddr;
    memPkg::memAddr              byteAddr;
    cpuPkg::accSize              curSize;
    logic [cpuPkg::dataBits-1:0] curWdata;
    logic [cpuPkg::dataBits-1:0] asmReg;
    logic [cpuPkg::dataBits-1:0] rawWord;
    logic [cpuPkg::dataBits-1:0] fullWord;

    logic finalStage;
    logic readBusy;
    logic capture;

    assign readBusy   = (state == fetchBusy) || (state == loadBusy);
    assign finalStage = (state != idle) && (stage == lastStage);

    always_comb begin
        case (curSize)
            cpuPkg::sizeByte: lastStage = 3'd1;
            cpuPkg::sizeHalf: lastStage = 3'd2;
            default:          lastStage = 3'd4;
        endcase
    end

    // data port has priority over fetch
    assign dataPop  = (state == idle) && !ioFull && dataValid;
    assign fetchPop = (state == idle) && !ioFull && !dataValid && fetchValid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            stage <= '0;
        end else if (!ioFull) begin
            case (state)
                idle: begin
                    stage <= '0;
                    if (dataPop) begin
                        state <= (dataHead.op == cpuPkg::opStore) ? storeBusy : loadBusy;
                    end else if (fetchPop) begin
                        state <= fetchBusy;
                    end
                end
                default: begin
                    if (finalStage) begin
                        state <= idle;
                        stage <= '0;
                    end else begin
                        stage <= stage + 1'b1;
                    end
                end
            endcase
        end
    end

    // latched request fields
    always_ff @(posedge clk) begin
        if (dataPop) begin
            curAddr  <= dataHead.addr;
            curSize  <= dataHead.size;
            curWdata <= dataHead.wdata;
        end else if (fetchPop) begin
            curAddr  <= fetchHead.addr;
            curSize  <= cpuPkg::sizeWord;
            curWdata <= '0;
        end
    end

    // byte k-1 arrives while stage k is active
    assign capture = readBusy && (stage != '0) && !finalStage && !ioFull;

    always_ff @(posedge clk) begin
        if (dataPop || fetchPop) begin
            asmReg <= '0;
        end else if (capture) begin
            asmReg <= {rdByte, asmReg[cpuPkg::dataBits-1:8]};
        end
    end

    // a stall keeps the previous address so rdByte still holds the pending byte
    always_comb begin
        byteAddr = curAddr + memPkg::memAddr'(stage);
        if (ioFull && (stage != '0)) begin
            byteAddr = byteAddr - 1'b1;
        end
    end

    always_comb begin
        cmd       = memPkg::ramIdleCmd;
        cmd.addr  = byteAddr;
        cmd.we    = (state == storeBusy) && !finalStage && !ioFull;
        cmd.wdata = curWdata[stage[1:0]*8 +: 8];
    end

    // little-endian assembly, zero-extended for short loads
    assign rawWord = {rdByte, asmReg[cpuPkg::dataBits-1:8]};

    always_comb begin
        case (curSize)
            cpuPkg::sizeByte: fullWord = {24'b0, rawWord[31:24]};
            cpuPkg::sizeHalf: fullWord = {16'b0, rawWord[31:16]};
            default:          fullWord = rawWord;
        endcase
    end

    always_comb begin
        fetchResp.valid = (state == fetchBusy) && finalStage && !ioFull;
        fetchResp.rdata = fullWord;
        dataResp.valid  = ((state == loadBusy) || (state == storeBusy)) && finalStage && !ioFull;
        dataResp.rdata  = (state == loadBusy) ? fullWord : '0;
    end

    bothPopCheck: assert property (
        @(posedge clk) disable iff (rst)
        !(fetchPop && dataPop)
    );

    writeStateCheck: assert property (
        @(posedge clk) disable iff (rst)
        cmd.we |-> (state == storeBusy)
    );

    // response closes the access, controller is idle next cycle
    respStageCheck: assert property (
        @(posedge clk) disable iff (rst)
        (fetchResp.valid || dataResp.valid) |-> finalStage ##1 (state == idle)
    );

endmodule

// File: hw/byteRam.sv
`timescale 1ns/100ps

module byteRam #(
    parameter int addrBits = memPkg::memAddrBits
) (
    input  logic           clk,
    input  memPkg::ramCmd  cmd,
    output memPkg::memByte rdByte
);

    localparam int numBytes = 2 ** addrBits;

    memPkg::memByte mem [numBytes];

    logic [addrBits-1:0] index;

    assign index = cmd.addr[addrBits-1:0];

    always_ff @(posedge clk) begin
        if (cmd.we) begin
            mem[index] <= cmd.wdata;
        end
    end

    // registered read, old data on a same-cycle write
    always_ff @(posedge clk) begin
        rdByte <= mem[index];
    end

endmodule

// File: hw/memSubsys.sv
`timescale 1ns/100ps

module memSubsys (
    input  logic           clk,
    input  logic           rst,
    input  logic           ioFull,
    input  cpuPkg::memReq  fetchReq,
    input  logic           fetchPush,
    output logic           fetchCredit,
    input  cpuPkg::memReq  dataReq,
    input  logic           dataPush,
    output logic           dataCredit,
    output cpuPkg::memResp fetchResp,
    output cpuPkg::memResp dataResp
);

    cpuPkg::memReq  fetchHead;
    cpuPkg::memReq  dataHead;
    logic           fetchValid;
    logic           dataValid;
    logic           fetchPop;
    logic           dataPop;
    memPkg::ramCmd  cmd;
    memPkg::memByte rdByte;

    reqQueue #(.depth(cpuPkg::fetchDepth)) fetchQueue (
        .clk       (clk),
        .rst       (rst),
        .push      (fetchPush),
        .inReq     (fetchReq),
        .pop       (fetchPop),
        .head      (fetchHead),
        .notEmpty  (fetchValid),
        .creditRet (fetchCredit)
    );

    reqQueue #(.depth(cpuPkg::dataDepth)) dataQueue (
        .clk       (clk),
        .rst       (rst),
        .push      (dataPush),
        .inReq     (dataReq),
        .pop       (dataPop),
        .head      (dataHead),
        .notEmpty  (dataValid),
        .creditRet (dataCredit)
    );

    memCtrl ctrl (
        .clk        (clk),
        .rst        (rst),
        .ioFull     (ioFull),
        .fetchHead  (fetchHead),
        .dataHead   (dataHead),
        .fetchValid (fetchValid),
        .dataValid  (dataValid),
        .fetchPop   (fetchPop),
        .dataPop    (dataPop),
        .cmd        (cmd),
        .rdByte     (rdByte),
        .fetchResp  (fetchResp),
        .dataResp   (dataResp)
    );

    byteRam #(.addrBits(memPkg::memAddrBits)) ram (
        .clk    (clk),
        .cmd    (cmd),
        .rdByte (rdByte)
    );

endmodule

// File: testbench/tbMemSubsys.sv
`timescale 1ns/100ps

module tbMemSubsys;

    localparam int preloadCount  = 65;
    localparam int directedCount = 11;
    localparam int randomCount   = 400;
    localparam int reqTotal      = preloadCount + directedCount + randomCount;
    localparam logic [15:0] winBase = 16'h1200;

    logic           clk;
    logic           rst;
    logic           ioFull;
    cpuPkg::memReq  fetchReq;
    logic           fetchPush;
    logic           fetchCredit;
    cpuPkg::memReq  dataReq;
    logic           dataPush;
    logic           dataCredit;
    cpuPkg::memResp fetchResp;
    cpuPkg::memResp dataResp;

    integer seed;

    // reference RAM and the bytes a store has already reached
    logic [7:0] model [2**memPkg::memAddrBits];
    bit         written [2**memPkg::memAddrBits];

    cpuPkg::memReq fetchPend [$];
    cpuPkg::memReq dataPend [$];
    int            dataPushCyc [$];

    int creditF;
    int creditD;
    int pushF;
    int pushD;
    int respF;
    int respD;
    int cyc;
    bit accBusy;
    bit accPort;
    int accStart;
    int accStall;
    int lastStall;

    memSubsys i_dut (
        .clk         (clk),
        .rst         (rst),
        .ioFull      (ioFull),
        .fetchReq    (fetchReq),
        .fetchPush   (fetchPush),
        .fetchCredit (fetchCredit),
        .dataReq     (dataReq),
        .dataPush    (dataPush),
        .dataCredit  (dataCredit),
        .fetchResp   (fetchResp),
        .dataResp    (dataResp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stopRun();
        $display("Simulation FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    function automatic int byteCount(input cpuPkg::accSize size);
        case (size)
            cpuPkg::sizeByte: return 1;
            cpuPkg::sizeHalf: return 2;
            default:          return 4;
        endcase
    endfunction

    function automatic cpuPkg::memReq makeReq(input cpuPkg::memOp op, input cpuPkg::accSize size,
                                              input logic [15:0] addr, input logic [31:0] wdata);
        cpuPkg::memReq req;
        req.op    = op;
        req.size  = size;
        req.addr  = addr;
        req.wdata = wdata;
        return req;
    endfunction

    function automatic cpuPkg::memReq randomData();
        logic [31:0]    r;
        cpuPkg::accSize size;
        cpuPkg::memOp   op;
        r = $random(seed);
        size = (r[1:0] == 2'd0) ? cpuPkg::sizeByte :
               (r[1:0] == 2'd1) ? cpuPkg::sizeHalf : cpuPkg::sizeWord;
        op = r[2] ? cpuPkg::opStore : cpuPkg::opLoad;
        return makeReq(op, size, winBase + {8'h00, r[15:8]}, $random(seed));
    endfunction

    function automatic cpuPkg::memReq randomFetch();
        logic [31:0] r;
        r = $random(seed);
        return makeReq(cpuPkg::opLoad, cpuPkg::sizeWord, winBase + {8'h00, r[7:0]}, 32'h0);
    endfunction

    // little-endian bytes from the model with zeroed upper bytes
    function automatic logic [31:0] loadValue(input logic [15:0] addr, input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = model[addr + 16'(i)];
        end
        return v;
    endfunction

    function automatic bit allWritten(input logic [15:0] addr, input int n);
        bit ok;
        ok = 1'b1;
        for (int i = 0; i < n; i++) begin
            ok = ok && written[addr + 16'(i)];
        end
        return ok;
    endfunction

    task automatic startAccess(input bit port);
        assert (!accBusy) else begin
            $display("a queue was popped while another access was still running");
            stopRun();
        end
        accBusy  = 1'b1;
        accPort  = port;
        accStart = cyc;
        accStall = 0;
    endtask

    task automatic finishAccess(input bit port, input logic [31:0] rdata);
        cpuPkg::memReq req;
        logic [31:0]   expVal;
        int            n;
        int            lat;
        string         sig;
        sig = port ? "dataResp" : "fetchResp";
        assert (accBusy && accPort == port) else begin
            $display("%s pulsed without an access in progress on that port", sig);
            stopRun();
        end
        assert ((port ? dataPend.size() : fetchPend.size()) > 0) else begin
            $display("%s pulsed with no request outstanding on that port", sig);
            stopRun();
        end
        if (port) begin
            req = dataPend.pop_front();
            dataPushCyc.delete(0);
            respD++;
        end else begin
            req = fetchPend.pop_front();
            respF++;
        end
        accBusy   = 1'b0;
        lastStall = accStall;
        n   = byteCount(req.size);
        lat = cyc - accStart - accStall;
        // response lands n cycles after creditRet plus any stalled cycles
        assert (lat == n) else begin
            $display("ERR %s latency exp=%h got=%h", sig, n, lat);
            stopRun();
        end
        if (req.op == cpuPkg::opStore) begin
            for (int i = 0; i < n; i++) begin
                model[req.addr + 16'(i)]   = req.wdata[8*i +: 8];
                written[req.addr + 16'(i)] = 1'b1;
            end
            expVal = '0;
            assert (rdata === expVal) else begin
                $display("ERR %s.rdata exp=%h got=%h", sig, expVal, rdata);
                stopRun();
            end
        end else if (allWritten(req.addr, n)) begin
            expVal = loadValue(req.addr, n);
            assert (rdata === expVal) else begin
                $display("ERR %s.rdata exp=%h got=%h", sig, expVal, rdata);
                stopRun();
            end
        end
    endtask

    // take credits and drive inputs on the falling edge before sampling responses
    task automatic stepCycle(input logic wantF, input cpuPkg::memReq reqF,
                             input logic wantD, input cpuPkg::memReq reqD, input logic stall);
        @(negedge clk);
        cyc++;
        if (fetchCredit) begin
            creditF++;
            // data pushed two or more cycles back must have been served first
            assert (dataPushCyc.size() == 0 || dataPushCyc[0] >= cyc - 1) else begin
                $display("fetch was popped while an older data request was waiting");
                stopRun();
            end
            startAccess(1'b0);
        end
        if (dataCredit) begin
            creditD++;
            startAccess(1'b1);
        end
        assert (creditF <= cpuPkg::fetchDepth && creditD <= cpuPkg::dataDepth) else begin
            $display("ERR credit count exp=%h/%h got=%h/%h",
                     cpuPkg::fetchDepth, cpuPkg::dataDepth, creditF, creditD);
            stopRun();
        end
        fetchPush = 1'b0;
        dataPush  = 1'b0;
        if (wantF && creditF > 0) begin
            fetchReq  = reqF;
            fetchPush = 1'b1;
            creditF--;
            fetchPend.push_back(reqF);
            pushF++;
        end
        if (wantD && creditD > 0) begin
            dataReq  = reqD;
            dataPush = 1'b1;
            creditD--;
            dataPend.push_back(reqD);
            dataPushCyc.push_back(cyc);
            pushD++;
        end
        ioFull = stall;
        if (accBusy && stall) begin
            accStall++;
        end
        #1;
        if (fetchResp.valid) begin
            finishAccess(1'b0, fetchResp.rdata);
        end
        if (dataResp.valid) begin
            finishAccess(1'b1, dataResp.rdata);
        end
    endtask

    task automatic drainAll();
        while (fetchPend.size() > 0 || dataPend.size() > 0) begin
            stepCycle(1'b0, '0, 1'b0, '0, 1'b0);
        end
    endtask

    // lone request from an idle system with ioFull raised for stallLen steps from stallAt
    task automatic singleAccess(input bit port, input cpuPkg::memReq req,
                                input int stallAt, input int stallLen);
        int target;
        int step;
        target = port ? respD + 1 : respF + 1;
        step = 0;
        stepCycle(!port, req, port, req, 1'b0);
        while ((port ? respD : respF) < target) begin
            step++;
            stepCycle(1'b0, req, 1'b0, req, step >= stallAt && step < stallAt + stallLen);
        end
        assert (lastStall == stallLen) else begin
            $display("ERR stall cycles exp=%h got=%h", stallLen, lastStall);
            stopRun();
        end
    endtask

    initial begin
        repeat (reqTotal * 12 + 200) @(posedge clk);
        $display("watchdog expired before all responses arrived");
        stopRun();
    end

    initial begin
        logic [31:0] r;
        seed      = 4;
        rst       = 1'b1;
        ioFull    = 1'b0;
        fetchPush = 1'b0;
        dataPush  = 1'b0;
        fetchReq  = '0;
        dataReq   = '0;
        creditF   = cpuPkg::fetchDepth;
        creditD   = cpuPkg::dataDepth;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        assert (!fetchResp.valid && !dataResp.valid && !fetchCredit && !dataCredit) else begin
            $display("response or credit pulse active right after reset");
            stopRun();
        end

        // fill the whole window with word stores
        while (pushD < preloadCount) begin
            stepCycle(1'b0, '0, 1'b1, makeReq(cpuPkg::opStore, cpuPkg::sizeWord,
                      winBase + 16'(4 * pushD), $random(seed)), 1'b0);
        end
        drainAll();

        singleAccess(1'b1, makeReq(cpuPkg::opStore, cpuPkg::sizeByte, winBase + 16'd20,
                     32'h0000_00a5), 0, 0);
        singleAccess(1'b1, makeReq(cpuPkg::opStore, cpuPkg::sizeHalf, winBase + 16'd22,
                     32'h0000_c3d2), 0, 0);
        singleAccess(1'b1, makeReq(cpuPkg::opStore, cpuPkg::sizeWord, winBase + 16'd24,
                     32'h8bad_f00d), 0, 0);
        singleAccess(1'b1, makeReq(cpuPkg::opLoad, cpuPkg::sizeByte, winBase + 16'd20, '0), 0, 0);
        singleAccess(1'b1, makeReq(cpuPkg::opLoad, cpuPkg::sizeHalf, winBase + 16'd22, '0), 0, 0);
        singleAccess(1'b1, makeReq(cpuPkg::opLoad, cpuPkg::sizeWord, winBase + 16'd24, '0), 0, 0);
        singleAccess(1'b0, makeReq(cpuPkg::opLoad, cpuPkg::sizeWord, winBase + 16'd23, '0), 0, 0);

        // stalls land after the pop inside the access
        singleAccess(1'b1, makeReq(cpuPkg::opLoad, cpuPkg::sizeWord, winBase + 16'd40, '0), 3, 2);
        singleAccess(1'b0, makeReq(cpuPkg::opLoad, cpuPkg::sizeWord, winBase + 16'd81, '0), 3, 3);
        singleAccess(1'b1, makeReq(cpuPkg::opStore, cpuPkg::sizeHalf, winBase + 16'd9,
                     32'h0000_5e71), 4, 1);
        singleAccess(1'b1, makeReq(cpuPkg::opLoad, cpuPkg::sizeWord, winBase + 16'd8, '0), 5, 2);

        while (pushF + pushD < preloadCount + directedCount + randomCount) begin
            r = $random(seed);
            stepCycle(r[2:0] == 3'd0, randomFetch(), r[5:3] == 3'd0, randomData(),
                      r[8:6] == 3'd0);
        end
        drainAll();
        stepCycle(1'b0, '0, 1'b0, '0, 1'b0);

        assert (creditF == cpuPkg::fetchDepth && creditD == cpuPkg::dataDepth) else begin
            $display("ERR idle credits exp=%h/%h got=%h/%h",
                     cpuPkg::fetchDepth, cpuPkg::dataDepth, creditF, creditD);
            stopRun();
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: byteMem.f
hw/memPkg.sv
hw/cpuPkg.sv
hw/reqQueue.sv
hw/memCtrl.sv
hw/byteRam.sv
hw/memSubsys.sv
testbench/tbMemSubsys.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the memory subsystem testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tbMemSubsys \
    --Mdir obj_dir \
    -o simMemSubsys \
    -f byteMem.f

./obj_dir/simMemSubsys 2>&1 | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
    echo "run.sh: pass"
else
    echo "run.sh: fail"
    exit 1
fi
